/* verilog/pid_pkg.sv */
package pid_pkg;

	////////////////////////////////////////
	// widths and channel counts
	////////////////////////////////////////
	localparam int N_ADC      = 4;	// adc channels
	localparam int N_DAC      = 4;	// dac channels
	localparam int W_ADC      = 18;	// adc sample width
	localparam int W_COMP     = 40;	// pid computation width
	localparam int W_EP       = 16;	// config word
	localparam int W_DAC_DATA = 16;	// dac code
	localparam int W_OSM      = 2;	// oversample mode, block of 2^osm
	localparam int W_SEL      = 2;	// router source index
	localparam int W_MLT      = 8;	// preprocessor multiplier

	localparam logic [3:0] DAC_CMD_WRUPD = 4'b0011;	// write input reg n, update dac n

	typedef logic [W_ADC-1:0] sample_t;
	typedef logic signed [W_COMP-1:0] comp_t;
	typedef logic [W_DAC_DATA-1:0] dac_code_t;

	typedef struct packed {
		logic [W_EP-1:0]        setpoint;	// unsigned, compared against the raw sample
		logic signed [W_EP-1:0] p_coef;
		logic signed [W_EP-1:0] i_coef;
		logic signed [W_EP-1:0] d_coef;
	} pid_cfg_s;

	typedef struct packed {
		dac_code_t        min;
		dac_code_t        max;
		dac_code_t        init;	// code for a zero pid value
		logic [W_MLT-1:0] mult;
	} opp_cfg_s;

	typedef struct packed {
		logic             active;
		logic [W_SEL-1:0] src;	// pid channel feeding this output
	} route_s;

	typedef struct packed {
		comp_t value;
		logic  valid;
	} chan_data_s;

	// dac8568 write frame, msb first on the wire
	typedef struct packed {
		logic [3:0] prefix;
		logic [3:0] command;
		logic [3:0] address;
		dac_code_t  data;
		logic [3:0] feature;
	} dac_frame_s;

	typedef union packed {
		dac_frame_s  fields;	// queue side
		logic [31:0] raw;	// shifter side
	} dac_frame_u;

	typedef enum logic [3:0] {
		ADDR_SETPOINT = 4'd0,
		ADDR_P        = 4'd1,
		ADDR_I        = 4'd2,
		ADDR_D        = 4'd3,
		ADDR_OSM      = 4'd4,
		ADDR_MULT     = 4'd5,
		ADDR_MIN      = 4'd6,
		ADDR_MAX      = 4'd7,
		ADDR_INIT     = 4'd8,
		ADDR_ROUTE0   = 4'd9,	// route k lives at 9 + k
		ADDR_ROUTE1   = 4'd10,
		ADDR_ROUTE2   = 4'd11,
		ADDR_ROUTE3   = 4'd12,
		ADDR_CLEAR    = 4'd15	// integrator clear mask, acts at once
	} cfg_addr_e;

endpackage

/* verilog/config_regs.sv */
`timescale 1ns/1ps

module config_regs import pid_pkg::*; #(
	parameter int n_adc = N_ADC,
	parameter int n_dac = N_DAC
) (
	input  logic             clk50,
	input  logic             arst_n,
	input  logic             cfg_we,
	input  cfg_addr_e        cfg_addr,
	input  logic [W_EP-1:0]  cfg_data,
	input  logic             cfg_update,
	output pid_cfg_s         pid_cfg,
	output opp_cfg_s         opp_cfg,
	output logic [W_OSM-1:0] osm,
	output route_s           route [n_dac],
	output logic [n_adc-1:0] pid_clear
);

	localparam pid_cfg_s PID_RST = '{setpoint: '0, p_coef: 16'sd1, i_coef: '0, d_coef: '0};
	localparam opp_cfg_s OPP_RST = '{min: 16'h0000, max: 16'hFFFF, init: 16'h8000, mult: 8'd1};

	pid_cfg_s         sh_pid;	// shadow set, written by cfg_we
	opp_cfg_s         sh_opp;
	logic [W_OSM-1:0] sh_osm;
	route_s           sh_route [n_dac];

	////////////////////////////////////////
	// shadow registers
	////////////////////////////////////////
	always_ff @(posedge clk50 or negedge arst_n) begin
		if (!arst_n) begin
			sh_pid <= PID_RST;
			sh_opp <= OPP_RST;
			sh_osm <= '0;
			for (int k = 0; k < n_dac; k++)
				sh_route[k] <= '{active: 1'b1, src: W_SEL'(k)};	// straight through
		end else if (cfg_we) begin
			case (cfg_addr)
				ADDR_SETPOINT: sh_pid.setpoint <= cfg_data;
				ADDR_P:        sh_pid.p_coef   <= cfg_data;
				ADDR_I:        sh_pid.i_coef   <= cfg_data;
				ADDR_D:        sh_pid.d_coef   <= cfg_data;
				ADDR_OSM:      sh_osm          <= cfg_data[W_OSM-1:0];
				ADDR_MULT:     sh_opp.mult     <= cfg_data[W_MLT-1:0];
				ADDR_MIN:      sh_opp.min      <= cfg_data;
				ADDR_MAX:      sh_opp.max      <= cfg_data;
				ADDR_INIT:     sh_opp.init     <= cfg_data;
				default: ;	// routes and clear handled below
			endcase
			for (int k = 0; k < n_dac; k++)
				if (cfg_addr == cfg_addr_e'(int'(ADDR_ROUTE0) + k))
					sh_route[k] <= cfg_data[W_SEL:0];	// {active, src}
		end
	end

	////////////////////////////////////////
	// active set, copied on update
	////////////////////////////////////////
	always_ff @(posedge clk50 or negedge arst_n) begin
		if (!arst_n) begin
			pid_cfg <= PID_RST;
			opp_cfg <= OPP_RST;
			osm     <= '0;
			for (int k = 0; k < n_dac; k++)
				route[k] <= '{active: 1'b1, src: W_SEL'(k)};
		end else if (cfg_update) begin
			pid_cfg <= sh_pid;
			opp_cfg <= sh_opp;
			osm     <= sh_osm;
			route   <= sh_route;
		end
	end

	// clear bypasses the shadow set, one pulse per mask bit
	always_ff @(posedge clk50 or negedge arst_n) begin
		if (!arst_n)
			pid_clear <= '0;
		else
			pid_clear <= (cfg_we && cfg_addr == ADDR_CLEAR) ? cfg_data[n_adc-1:0] : '0;
	end

endmodule

/* verilog/oversample_filter.sv */
`timescale 1ns/1ps

module oversample_filter import pid_pkg::*; (
	input  logic             clk50,
	input  logic             arst_n,
	input  logic [W_OSM-1:0] osm,
	input  sample_t          sample,
	input  logic             sample_valid,
	output sample_t          avg,
	output logic             avg_valid
);

	localparam int OSM_MAX = (1 << W_OSM) - 1;	// largest shift, 3
	localparam int W_SUM   = W_ADC + OSM_MAX;	// 21 bits holds 8 samples

	logic [W_SUM-1:0]   sum_q;
	logic [W_SUM-1:0]   sum_next;	// block sum including this sample
	logic [OSM_MAX-1:0] cnt_q;	// samples already in the block
	logic               last;

	assign sum_next = sum_q + W_SUM'(sample);
	// >= so a smaller osm mid-block still closes the block
	assign last = ({1'b0, cnt_q} >= ((4'd1 << osm) - 4'd1));

	always_ff @(posedge clk50 or negedge arst_n) begin
		if (!arst_n) begin
			sum_q     <= '0;
			cnt_q     <= '0;
			avg_valid <= 1'b0;
		end else begin
			avg_valid <= sample_valid && last;
			if (sample_valid) begin
				sum_q <= last ? '0 : sum_next;	// restart block after the last sample
				cnt_q <= last ? '0 : cnt_q + 1'b1;
			end
		end
	end

	// floor of the mean, the shift drops the remainder
	always_ff @(posedge clk50) begin
		if (sample_valid && last)
			avg <= sample_t'(sum_next >> osm);
	end

endmodule

/* verilog/pid_core.sv */
`timescale 1ns/1ps

module pid_core import pid_pkg::*; (
	input  logic       clk50,
	input  logic       arst_n,
	input  pid_cfg_s   cfg,
	input  logic       clear,
	input  sample_t    din,
	input  logic       din_valid,
	output chan_data_s dout
);

	logic signed [W_ADC:0]   err;	// setpoint - sample, one extra bit for sign
	logic signed [W_ADC:0]   err_prev;
	logic signed [W_ADC+1:0] err_diff;	// derivative input
	comp_t                   i_step;
	comp_t                   p_term;
	comp_t                   d_term;
	comp_t                   integ;	// running integral
	comp_t                   sum_q;
	logic                    v1_q;	// stage 1 valid
	logic                    v2_q;	// stage 2 valid

	assign err      = $signed({{(W_ADC + 1 - W_EP){1'b0}}, cfg.setpoint}) - $signed({1'b0, din});
	assign err_diff = err - err_prev;
	assign i_step   = comp_t'(cfg.i_coef) * comp_t'(err);

	////////////////////////////////////////
	// stage 1  products and integrator
	////////////////////////////////////////
	always_ff @(posedge clk50) begin
		if (din_valid) begin
			p_term <= comp_t'(cfg.p_coef) * comp_t'(err);
			d_term <= comp_t'(cfg.d_coef) * comp_t'(err_diff);
		end
	end

	always_ff @(posedge clk50 or negedge arst_n) begin
		if (!arst_n) begin
			integ    <= '0;
			err_prev <= '0;
			v1_q     <= 1'b0;
		end else begin
			v1_q <= din_valid;
			if (clear) begin	// wins over a sample in the same cycle
				integ    <= '0;
				err_prev <= '0;
			end else if (din_valid) begin
				integ    <= integ + i_step;
				err_prev <= err;
			end
		end
	end

	////////////////////////////////////////
	// stage 2  sum of terms
	////////////////////////////////////////
	always_ff @(posedge clk50) begin
		if (v1_q)
			sum_q <= p_term + integ + d_term;	// integ already holds this sample
	end

	always_ff @(posedge clk50 or negedge arst_n) begin
		if (!arst_n)
			v2_q <= 1'b0;
		else
			v2_q <= v1_q;
	end

	assign dout = '{value: sum_q, valid: v2_q};

endmodule

/* verilog/router.sv */
`timescale 1ns/1ps

module router import pid_pkg::*; #(
	parameter int n_adc = N_ADC,
	parameter int n_dac = N_DAC
) (
	input  chan_data_s inputs  [n_adc],	// one per pid core
	input  route_s     route   [n_dac],	// one per output
	output chan_data_s outputs [n_dac]
);

	// one source may fan out to several outputs
	always_comb begin
		for (int k = 0; k < n_dac; k++) begin
			outputs[k]       = inputs[route[k].src];
			outputs[k].valid = inputs[route[k].src].valid & route[k].active;	// inactive => silent
		end
	end

endmodule

/* verilog/output_preprocessor.sv */
`timescale 1ns/1ps

module output_preprocessor import pid_pkg::*; (
	input  logic       clk50,
	input  logic       arst_n,
	input  opp_cfg_s   cfg,
	input  chan_data_s din,
	output dac_code_t  code,
	output logic       code_valid
);

	localparam int W_SUM = W_COMP + W_MLT + 2;	// product plus sign plus carry of init

	logic signed [W_SUM-1:0] scaled;	// init + value * mult, no truncation
	logic signed [W_SUM-1:0] lo;
	logic signed [W_SUM-1:0] hi;
	dac_code_t               code_next;

	assign lo = {{(W_SUM - W_DAC_DATA){1'b0}}, cfg.min};
	assign hi = {{(W_SUM - W_DAC_DATA){1'b0}}, cfg.max};

	// multiplier is unsigned, zero-extended before the signed multiply
	assign scaled = W_SUM'(din.value) * $signed({{(W_SUM - W_MLT){1'b0}}, cfg.mult})
		+ $signed({{(W_SUM - W_DAC_DATA){1'b0}}, cfg.init});

	// clamp to the dac code window
	always_comb begin
		if (scaled < lo)
			code_next = cfg.min;
		else if (scaled > hi)
			code_next = cfg.max;
		else
			code_next = scaled[W_DAC_DATA-1:0];
	end

	always_ff @(posedge clk50) begin
		if (din.valid)
			code <= code_next;
	end

	always_ff @(posedge clk50 or negedge arst_n) begin
		if (!arst_n)
			code_valid <= 1'b0;
		else
			code_valid <= din.valid;	// 1 cycle latency
	end

endmodule

/* verilog/dac_instr_queue.sv */
`timescale 1ns/1ps

module dac_instr_queue import pid_pkg::*; #(
	parameter int n_dac = N_DAC
) (
	input  logic             clk50,
	input  logic             arst_n,
	input  dac_code_t        code [n_dac],
	input  logic [n_dac-1:0] code_valid,
	output dac_frame_u       frame,
	output logic             frame_valid,	// held until done
	input  logic             done
);

	localparam int W_IDX = $clog2(n_dac);

	dac_code_t        held [n_dac];	// newest code per channel
	logic [n_dac-1:0] pend;
	logic [W_IDX-1:0] last_q;	// channel issued last
	logic [W_IDX-1:0] pick;
	logic             found;
	logic             issue;

	// round robin, search starts just after the last issued channel
	always_comb begin
		pick  = last_q;
		found = 1'b0;
		for (int i = 1; i <= n_dac; i++) begin
			if (!found && pend[(int'(last_q) + i) % n_dac]) begin
				pick  = W_IDX'((int'(last_q) + i) % n_dac);
				found = 1'b1;
			end
		end
	end

	assign issue = found && !frame_valid;	// only when the shifter link is free

	always_ff @(posedge clk50 or negedge arst_n) begin
		if (!arst_n) begin
			pend        <= '0;
			last_q      <= W_IDX'(n_dac - 1);	// first issue goes to channel 0
			frame_valid <= 1'b0;
		end else begin
			for (int k = 0; k < n_dac; k++) begin
				if (code_valid[k])
					pend[k] <= 1'b1;	// new code keeps the channel pending
				else if (issue && int'(pick) == k)
					pend[k] <= 1'b0;
			end
			if (issue) begin
				frame_valid <= 1'b1;
				last_q      <= pick;
			end else if (done) begin
				frame_valid <= 1'b0;
			end
		end
	end

	always_ff @(posedge clk50) begin
		for (int k = 0; k < n_dac; k++)
			if (code_valid[k])
				held[k] <= code[k];	// overwrite, older value lost
		if (issue)
			frame.fields <= '{prefix: 4'h0, command: DAC_CMD_WRUPD, address: 4'(pick),
				data: held[pick], feature: 4'h0};
	end

endmodule

/* verilog/dac_controller.sv */
`timescale 1ns/1ps

module dac_controller import pid_pkg::*; (
	input  logic       clk50,
	input  logic       arst_n,
	input  dac_frame_u frame,
	input  logic       frame_valid,
	output logic       done,	// one pulse per frame
	output logic       dac_sclk,
	output logic       dac_din,
	output logic       dac_nsync,
	output logic       dac_nldac,
	output logic       dac_nclr
);

	localparam int N_BITS = $bits(dac_frame_u);	// 32
	localparam int N_LOW  = 2 * N_BITS;	// nsync low cycles, sclk period 2
	localparam int W_CNT  = $clog2(N_LOW + 2);

	logic              busy;
	logic [W_CNT-1:0]  cnt;	// cycle within the frame, 1 while first bit is out
	logic [N_BITS-1:0] shreg;	// bits still to send, msb next
	logic              accept;
	logic              shift_en;

	// done blocks the cycle where the queue still shows the old frame
	assign accept   = frame_valid && !busy && !done;
	assign shift_en = busy && (cnt < W_CNT'(N_LOW)) && !dac_sclk;	// next bit on rising sclk

	always_ff @(posedge clk50 or negedge arst_n) begin
		if (!arst_n) begin
			busy      <= 1'b0;
			cnt       <= '0;
			done      <= 1'b0;
			dac_sclk  <= 1'b0;
			dac_din   <= 1'b0;
			dac_nsync <= 1'b1;
		end else begin
			done <= 1'b0;
			if (accept) begin
				busy      <= 1'b1;
				cnt       <= W_CNT'(1);
				dac_nsync <= 1'b0;
				dac_sclk  <= 1'b1;
				dac_din   <= frame.raw[N_BITS-1];	// msb with the first rising sclk
			end else if (busy) begin
				cnt <= cnt + 1'b1;
				if (cnt < W_CNT'(N_LOW)) begin
					dac_sclk <= ~dac_sclk;	// dac samples din on the falling edge
					if (shift_en)
						dac_din <= shreg[N_BITS-1];
				end else if (cnt == W_CNT'(N_LOW)) begin
					dac_nsync <= 1'b1;	// frame latched by the dac
					dac_din   <= 1'b0;
				end else begin
					busy <= 1'b0;
					cnt  <= '0;
					done <= 1'b1;	// 66 cycles after accept
				end
			end
		end
	end

	always_ff @(posedge clk50) begin
		if (accept)
			shreg <= frame.raw << 1;
		else if (shift_en)
			shreg <= shreg << 1;
	end

	assign dac_nldac = 1'b0;	// dac updates on each frame
	assign dac_nclr  = 1'b1;

endmodule

/* verilog/pid_controller.sv */
`timescale 1ns/1ps

module pid_controller import pid_pkg::*; #(
	parameter int n_adc = N_ADC,
	parameter int n_dac = N_DAC
) (
	input  logic             clk50,
	input  logic             arst_n,
	input  sample_t          sample_in [n_adc],
	input  logic [n_adc-1:0] sample_valid_in,
	input  logic             cfg_we,
	input  cfg_addr_e        cfg_addr,
	input  logic [W_EP-1:0]  cfg_data,
	input  logic             cfg_update,
	output logic             dac_sclk,
	output logic             dac_din,
	output logic             dac_nsync,
	output logic             dac_nldac,
	output logic             dac_nclr
);

	////////////////////////////////////////
	// internal links
	////////////////////////////////////////
	pid_cfg_s         pid_cfg;
	opp_cfg_s         opp_cfg;
	logic [W_OSM-1:0] osm;
	route_s           route [n_dac];
	logic [n_adc-1:0] pid_clear;
	sample_t          osf_data [n_adc];
	logic [n_adc-1:0] osf_valid;
	chan_data_s       pid_data [n_adc];
	chan_data_s       rtr_data [n_dac];	// per dac output
	dac_code_t        opp_code [n_dac];
	logic [n_dac-1:0] opp_valid;
	dac_frame_u       diq_frame;
	logic             diq_valid;
	logic             dac_done;

	config_regs #(.n_adc(n_adc), .n_dac(n_dac)) cfg_regs (
		.clk50, .arst_n, .cfg_we, .cfg_addr, .cfg_data, .cfg_update,
		.pid_cfg, .opp_cfg, .osm, .route, .pid_clear
	);

	// adc side, one filter and pid core per channel
	for (genvar m = 0; m < n_adc; m++) begin : adc_chan
		oversample_filter osf_inst (
			.clk50, .arst_n, .osm,
			.sample(sample_in[m]), .sample_valid(sample_valid_in[m]),
			.avg(osf_data[m]), .avg_valid(osf_valid[m])
		);

		pid_core pid_inst (
			.clk50, .arst_n, .cfg(pid_cfg), .clear(pid_clear[m]),
			.din(osf_data[m]), .din_valid(osf_valid[m]), .dout(pid_data[m])
		);
	end

	router #(.n_adc(n_adc), .n_dac(n_dac)) rtr (
		.inputs(pid_data), .route, .outputs(rtr_data)
	);

	// dac side
	for (genvar x = 0; x < n_dac; x++) begin : dac_chan
		output_preprocessor opp_inst (
			.clk50, .arst_n, .cfg(opp_cfg), .din(rtr_data[x]),
			.code(opp_code[x]), .code_valid(opp_valid[x])
		);
	end

	dac_instr_queue #(.n_dac(n_dac)) dac_iq (
		.clk50, .arst_n, .code(opp_code), .code_valid(opp_valid),
		.frame(diq_frame), .frame_valid(diq_valid), .done(dac_done)
	);

	dac_controller dac_cntrl (
		.clk50, .arst_n, .frame(diq_frame), .frame_valid(diq_valid), .done(dac_done),
		.dac_sclk, .dac_din, .dac_nsync, .dac_nldac, .dac_nclr
	);

endmodule

/* verification/tb_pid_controller.sv */
`timescale 1ns/1ps

module tb_pid_controller import pid_pkg::*; ();

	localparam int FRAME_TIMEOUT = 400;	// one frame needs about 75 cycles
	localparam int QUIET_CYCLES  = 150;	// longer than sample to done

	typedef struct packed {
		logic [3:0] addr;
		dac_code_t  data;
	} rx_frame_s;

	logic             clk50;
	logic             arst_n;
	sample_t          sample_in [N_ADC];
	logic [N_ADC-1:0] sample_valid_in;
	logic             cfg_we;
	cfg_addr_e        cfg_addr;
	logic [W_EP-1:0]  cfg_data;
	logic             cfg_update;
	logic             dac_sclk;
	logic             dac_din;
	logic             dac_nsync;
	logic             dac_nldac;
	logic             dac_nclr;

	int        value_errs = 0;
	int        other_errs = 0;
	rx_frame_s rx_q [$];	// decoded frames with the oldest first

	// reference model of the active config and per channel state
	pid_cfg_s  m_pid;
	opp_cfg_s  m_opp;
	int        m_osm;
	route_s    m_route [N_DAC];
	longint    integ [N_ADC];
	longint    eprev [N_ADC];
	longint    blk_sum [N_ADC];
	int        blk_cnt [N_ADC];

	pid_controller #(.n_adc(N_ADC), .n_dac(N_DAC)) dut0 (.*);

	always #4 clk50 = ~clk50;	// period 8 ns

	task automatic report_mismatch(input string name, input logic [31:0] got,
		input logic [31:0] exp);
		value_errs++;
		$display("Fail %s: got 0x%h, expected 0x%h", name, got, exp);
	endtask

	task automatic stop_on_timeout(input string why);
		other_errs++;
		$display("timeout: %s", why);
		$display("value errors: %0d, other errors: %0d", value_errs, other_errs);
		$display("Something failed");
		$finish;
	endtask

	////////////////////////////////////////
	// frame decoder sampled mid-cycle
	////////////////////////////////////////
	logic        sclk_d;
	logic        nsync_d;
	int          n_bits;
	int          n_rise;
	logic [31:0] word;	// dac_din bits of the open frame

	always @(negedge clk50) begin
		rx_frame_s f;
		if (!arst_n) begin
			sclk_d  = 1'b0;
			nsync_d = 1'b1;
			n_bits  = 0;
			n_rise  = 0;
		end else begin
			if (!dac_nsync && dac_sclk && !sclk_d)
				n_rise++;
			if (!dac_nsync && !dac_sclk && sclk_d) begin	// dac samples din here
				word = {word[30:0], dac_din};
				n_bits++;
			end
			if (dac_nsync && !nsync_d) begin	// nsync back high closes the frame
				assert (n_rise == 32) else report_mismatch("dac_sclk rising edges", n_rise, 32);
				assert (n_bits == 32) else report_mismatch("dac_din bit count", n_bits, 32);
				assert (word[31:24] == {4'h0, DAC_CMD_WRUPD} && word[3:0] == 4'h0)
					else report_mismatch("frame prefix/command", word[31:24], DAC_CMD_WRUPD);
				f.addr = word[23:20];
				f.data = word[19:4];
				rx_q.push_back(f);
				n_bits = 0;
				n_rise = 0;
			end
			sclk_d  = dac_sclk;
			nsync_d = dac_nsync;
		end
	end

	// ldac and clr are tied off in this design
	assert property (@(posedge clk50) disable iff (!arst_n) !dac_nldac && dac_nclr)
		else report_mismatch("dac_nldac/dac_nclr", {dac_nldac, dac_nclr}, 2'b01);

	////////////////////////////////////////
	// stimulus tasks
	////////////////////////////////////////
	task automatic write_reg(input cfg_addr_e a, input logic [W_EP-1:0] d);
		@(negedge clk50);
		cfg_we   = 1'b1;
		cfg_addr = a;
		cfg_data = d;
		@(negedge clk50);
		cfg_we = 1'b0;
	endtask

	task automatic commit_config();
		@(negedge clk50);
		cfg_update = 1'b1;	// shadow -> active on the next edge
		@(negedge clk50);
		cfg_update = 1'b0;
	endtask

	task automatic send_sample(input int k, input sample_t x);
		@(negedge clk50);
		sample_in[k]       = x;
		sample_valid_in[k] = 1'b1;
		@(negedge clk50);
		sample_valid_in[k] = 1'b0;
	endtask

	// averages the block, runs the pid sum and scales and clamps the code
	task automatic model_sample(input int k, input longint x, output bit emit,
		output longint code);
		longint avg;
		longint e;
		longint v;
		blk_sum[k] += x;
		blk_cnt[k]++;
		emit = (blk_cnt[k] == (1 << m_osm));
		code = 0;
		if (emit) begin
			avg        = blk_sum[k] >> m_osm;	// floor since the sum is never negative
			blk_sum[k] = 0;
			blk_cnt[k] = 0;
			e          = longint'(m_pid.setpoint) - avg;
			integ[k]  += longint'(m_pid.i_coef) * e;
			v          = longint'(m_pid.p_coef) * e + integ[k]
				+ longint'(m_pid.d_coef) * (e - eprev[k]);
			eprev[k]   = e;
			code       = longint'(m_opp.init) + v * longint'(m_opp.mult);
			if (code < longint'(m_opp.min))
				code = longint'(m_opp.min);
			else if (code > longint'(m_opp.max))
				code = longint'(m_opp.max);
		end
	endtask

	task automatic wait_frame(output rx_frame_s f);
		int n;
		n = 0;
		while (rx_q.size() == 0) begin
			if (n == FRAME_TIMEOUT)
				stop_on_timeout("no DAC frame arrived after a sample");
			@(posedge clk50);
			n++;
		end
		f = rx_q.pop_front();
	endtask

	task automatic expect_silence();
		repeat (QUIET_CYCLES) @(posedge clk50);
		assert (rx_q.size() == 0) else begin
			other_errs++;
			$display("a DAC frame arrived where none was expected");
			rx_q.delete();
		end
	endtask

	// every active output fed by channel k sends one frame
	task automatic expect_outputs(input int k, input longint code, output logic [15:0] got);
		logic [15:0] want;
		rx_frame_s   f;
		int          n;
		want = '0;
		got  = '0;
		for (int o = 0; o < N_DAC; o++)
			want[o] = m_route[o].active && (int'(m_route[o].src) == k);
		n = $countones(want);
		if (n == 0)
			expect_silence();
		repeat (n) begin
			wait_frame(f);
			assert (want[f.addr]) else report_mismatch("frame.address", f.addr, want);
			want[f.addr] = 1'b0;	// each output only once
			assert (f.data == dac_code_t'(code)) else report_mismatch("frame.data", f.data, code);
			got = f.data;
		end
	endtask

	task automatic check_sample(input int k, input longint x, output logic [15:0] got);
		bit     emit;
		longint code;
		send_sample(k, sample_t'(x));
		model_sample(k, x, emit, code);
		got = '0;
		if (emit)
			expect_outputs(k, code, got);
		else
			expect_silence();	// block not complete yet
	endtask

	////////////////////////////////////////
	// test sequence
	////////////////////////////////////////
	initial begin
		logic [15:0] got;
		logic [15:0] prev;
		void'($urandom(99));	// one seed for the whole run
		clk50      = 1'b0;
		arst_n     = 1'b0;
		cfg_we     = 1'b0;
		cfg_addr   = ADDR_SETPOINT;
		cfg_data   = '0;
		cfg_update = 1'b0;
		sample_valid_in = '0;
		m_pid = '{setpoint: 16'h0000, p_coef: 16'sd1, i_coef: 16'sd0, d_coef: 16'sd0};
		m_opp = '{min: 16'h0000, max: 16'hFFFF, init: 16'h8000, mult: 8'd1};
		m_osm = 0;
		for (int k = 0; k < N_ADC; k++) begin
			sample_in[k] = '0;
			integ[k]     = 0;
			eprev[k]     = 0;
			blk_sum[k]   = 0;
			blk_cnt[k]   = 0;
		end
		for (int o = 0; o < N_DAC; o++)
			m_route[o] = '{active: 1'b1, src: W_SEL'(o)};	// straight through
		repeat (16) @(negedge clk50);
		arst_n = 1'b1;

		repeat (40) begin	// idle link before any sample
			@(negedge clk50);
			assert (dac_nsync && !dac_sclk)
				else report_mismatch("dac_nsync/dac_sclk", {dac_nsync, dac_sclk}, 2'b10);
		end

		// reset config gives code 8000 - x
		for (int n = 0; n < 12; n++)
			check_sample(n % N_ADC, $urandom % 'h9000, got);
		check_sample(1, 'h3FFFF, got);	// far below min

		// shadow writes alone change nothing
		write_reg(ADDR_MIN, 16'h1000);
		write_reg(ADDR_MAX, 16'hF000);
		write_reg(ADDR_MULT, 16'h0003);
		write_reg(ADDR_SETPOINT, 16'hFFFF);
		check_sample(0, 'h100, got);
		commit_config();
		m_pid.setpoint = 16'hFFFF;
		m_opp          = '{min: 16'h1000, max: 16'hF000, init: 16'h8000, mult: 8'd3};
		check_sample(0, 'h0, got);	// large positive error
		assert (got == 16'hF000) else report_mismatch("frame.data at max", got, 16'hF000);
		check_sample(0, 'h3FFFF, got);	// large negative error
		assert (got == 16'h1000) else report_mismatch("frame.data at min", got, 16'h1000);
		check_sample(0, 'hFF00, got);

		// mid-scale setpoint keeps 16-bit samples inside the code range
		write_reg(ADDR_SETPOINT, 16'h8000);
		write_reg(ADDR_MULT, 16'h0001);
		write_reg(ADDR_MIN, 16'h0000);
		write_reg(ADDR_MAX, 16'hFFFF);
		commit_config();
		m_pid.setpoint = 16'h8000;
		m_opp          = '{min: 16'h0000, max: 16'hFFFF, init: 16'h8000, mult: 8'd1};

		// routing
		write_reg(ADDR_ROUTE1, 16'h0001);	// output 1 off
		commit_config();
		m_route[1].active = 1'b0;
		check_sample(1, 'h4000, got);
		write_reg(ADDR_ROUTE0, 16'h0006);	// output 0 <- channel 2
		commit_config();
		m_route[0].src = 2'd2;
		for (int n = 0; n < 3; n++)
			check_sample(2, $urandom & 'hFFFF, got);
		check_sample(0, 'h1234, got);	// channel 0 now feeds nothing
		write_reg(ADDR_ROUTE0, 16'h0004);
		write_reg(ADDR_ROUTE1, 16'h0005);
		commit_config();
		m_route[0] = '{active: 1'b1, src: 2'd0};
		m_route[1] = '{active: 1'b1, src: 2'd1};

		// blocks of four
		write_reg(ADDR_OSM, 16'h0002);
		commit_config();
		m_osm = 2;
		for (int n = 0; n < 8; n++)
			check_sample(3, $urandom & 'hFFFF, got);
		write_reg(ADDR_OSM, 16'h0000);
		commit_config();
		m_osm = 0;

		// pure integrator with an error of 1000 per sample
		write_reg(ADDR_P, 16'h0000);
		write_reg(ADDR_I, 16'h0001);
		commit_config();
		m_pid.p_coef = 16'sd0;
		m_pid.i_coef = 16'sd1;
		prev = 16'h8000;	// channel 0 integrator is still empty
		for (int n = 0; n < 4; n++) begin
			check_sample(0, 'h7000, got);
			assert (got - prev == 16'h1000)
				else report_mismatch("frame.data step", got - prev, 16'h1000);
			prev = got;
		end
		write_reg(ADDR_CLEAR, 16'h0001);
		integ[0] = 0;
		eprev[0] = 0;
		check_sample(0, 'h7000, got);
		assert (got == 16'h9000) else report_mismatch("frame.data after clear", got, 16'h9000);

		$display("value errors: %0d, other errors: %0d", value_errs, other_errs);
		if (value_errs == 0 && other_errs == 0)
			$display("Everything OK");
		else
			$display("Something failed");
		$finish;
	end

endmodule

/* sources.f */
verilog/pid_pkg.sv
verilog/config_regs.sv
verilog/oversample_filter.sv
verilog/pid_core.sv
verilog/router.sv
verilog/output_preprocessor.sv
verilog/dac_instr_queue.sv
verilog/dac_controller.sv
verilog/pid_controller.sv
verification/tb_pid_controller.sv

/* Makefile */
TOP = tb_pid_controller

compile:
	verilator --binary --timing --assert -Wno-fatal --top-module $(TOP) -f sources.f -o V$(TOP)

run: compile
	./obj_dir/V$(TOP) | tee sim.log
	grep -q "^Everything OK$$" sim.log

clean:
	rm -rf obj_dir sim.log

.PHONY: compile run clean
